//--- project.f
+incdir+.
icache_pkg.sv
fetch_req_stage.sv
icache_way_ram.sv
icache_ctrl.sv
icache_mem_port.sv
icache_top.sv
tb_mem_model.sv
tb_icache.sv

//--- tb_icache.sv
`timescale 1ns/10ps

module tb_icache;
    import icache_pkg::*;

    localparam int NUM_TESTS       = 6;
    localparam int CYCLES_PER_TEST = 400;
    localparam int WAIT_LIMIT      = 200;

    logic        clk;
    logic        reset;
    logic        fetch_en;
    addr_t       fetch_pc;
    logic        uncached;
    logic        flush;
    logic        stall;
    fetch_resp_t resp;
    logic        rd_req;
    addr_t       rd_addr;
    logic        ret_valid;
    line_t       ret_data;
    logic        unc_ren;
    addr_t       unc_addr;
    logic        unc_rvalid;
    word_t       unc_rdata;

    fetch_resp_t expq[$];
    fetch_resp_t exp_r;
    addr_t       line_addrs[$];  // rd_addr_o at each new line request
    addr_t       unc_addrs[$];
    logic        rd_req_d;
    logic        unc_ren_d;
    int          errors;
    int          checks;
    int          test_no;
    int          test_err0;

    icache_top u_dut (
        .clk, .reset,
        .fetch_en_i   (fetch_en),
        .fetch_pc_i   (fetch_pc),
        .uncached_i   (uncached),
        .flush_i      (flush),
        .stall_o      (stall),
        .resp_o       (resp),
        .rd_req_o     (rd_req),
        .rd_addr_o    (rd_addr),
        .ret_valid_i  (ret_valid),
        .ret_data_i   (ret_data),
        .unc_ren_o    (unc_ren),
        .unc_addr_o   (unc_addr),
        .unc_rvalid_i (unc_rvalid),
        .unc_rdata_i  (unc_rdata)
    );

    tb_mem_model u_mem (
        .clk, .reset,
        .rd_req_i     (rd_req),
        .rd_addr_i    (rd_addr),
        .ret_valid_o  (ret_valid),
        .ret_data_o   (ret_data),
        .unc_ren_i    (unc_ren),
        .unc_addr_i   (unc_addr),
        .unc_rvalid_o (unc_rvalid),
        .unc_rdata_o  (unc_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic word_t expected_word(input addr_t a);
        word_t w;
        w = ~a;
        return (w << 5) | (w >> 27);
    endfunction

    function automatic fetch_resp_t expected_resp(input addr_t pc, input logic unc);
        fetch_resp_t r;
        r.valid     = 1'b1;
        r.pc        = pc;
        r.slot_mask = unc ? 2'b01 : 2'b11;
        r.inst0     = unc ? (pc[31] ? pc ^ 32'h5a5a_0000 : expected_word(pc)) : expected_word(pc);
        r.inst1     = unc ? '0 : expected_word(pc + 32'd4);
        return r;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        assert (got == exp) else begin
            $display("FAILED %s: got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    // responses in order of acceptance
    always @(posedge clk) begin
        if (!reset && resp.valid) begin
            if (expq.size() == 0) begin
                $display("response for pc %h with no fetch outstanding", resp.pc);
                errors++;
            end else begin
                exp_r = expq.pop_front();
                check_value("resp_o.pc", resp.pc, exp_r.pc);
                check_value("resp_o.slot_mask", 32'(resp.slot_mask), 32'(exp_r.slot_mask));
                check_value("resp_o.inst0", resp.inst0, exp_r.inst0);
                if (exp_r.slot_mask[1]) check_value("resp_o.inst1", resp.inst1, exp_r.inst1);
            end
        end
    end

    always @(posedge clk) begin
        if (reset) begin
            rd_req_d  <= 1'b0;
            unc_ren_d <= 1'b0;
        end else begin
            rd_req_d  <= rd_req;
            unc_ren_d <= unc_ren;
            if (rd_req && !rd_req_d) line_addrs.push_back(rd_addr);
            if (unc_ren && !unc_ren_d) unc_addrs.push_back(unc_addr);
        end
    end

    // cache back to idle one cycle after a flush
    assert property (@(posedge clk) disable iff (reset)
        flush |=> !stall && !resp.valid && !rd_req && !unc_ren)
    else begin
        $display("cache not idle in the cycle after a flush");
        errors++;
    end

    task automatic issue_fetch(input addr_t pc, input logic unc, input logic expect_resp);
        int n;
        n = 0;
        fetch_en = 1'b1;
        fetch_pc = pc;
        uncached = unc;
        while (stall && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (n >= WAIT_LIMIT) begin
            $display("fetch of pc %h never accepted", pc);
            errors++;
        end
        @(posedge clk);
        @(negedge clk);
        if (expect_resp) expq.push_back(expected_resp(pc, unc));
        fetch_en = 1'b0;
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        while ((expq.size() != 0 || stall) && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (n >= WAIT_LIMIT) begin
            $display("timed out with %0d responses outstanding", expq.size());
            errors++;
        end
        @(negedge clk);  // a stray response would show here
    endtask

    task automatic fetch_and_count(input addr_t pc, input int exp_reqs);
        issue_fetch(pc, 1'b0, 1'b1);
        wait_drain();
        check_value("rd_req_o rising edges", line_addrs.size(), exp_reqs);
    endtask

    task automatic start_test();
        test_err0 = errors;
        line_addrs.delete();
        unc_addrs.delete();
    endtask

    task automatic end_test(input string name);
        test_no++;
        $display("test %0d %s: %0d errors", test_no, name, errors - test_err0);
    endtask

    initial begin
        int n;
        reset    = 1'b1;
        fetch_en = 1'b0;
        fetch_pc = '0;
        uncached = 1'b0;
        flush    = 1'b0;
        errors   = 0;
        checks   = 0;
        test_no  = 0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        checks++;
        assert (!stall && !resp.valid && !rd_req && !unc_ren) else begin
            $display("cache not idle after reset");
            errors++;
        end

        start_test();
        fetch_and_count(32'h0000_1040, 1);
        end_test("cold miss");

        start_test();
        issue_fetch(32'h0000_1040, 1'b0, 1'b1);
        issue_fetch(32'h0000_1048, 1'b0, 1'b1);
        issue_fetch(32'h0000_1050, 1'b0, 1'b1);
        issue_fetch(32'h0000_1058, 1'b0, 1'b1);
        wait_drain();
        check_value("rd_req_o rising edges", line_addrs.size(), 0);
        end_test("repeat hits");

        start_test();
        fetch_and_count(32'h0000_20bc, 2);  // second word in the next line
        if (line_addrs.size() == 2) begin
            check_value("rd_addr_o", line_addrs[0], 32'h0000_20a0);
            check_value("rd_addr_o", line_addrs[1], 32'h0000_20c0);
        end
        end_test("line crossing");

        start_test();
        issue_fetch(32'h8000_3100, 1'b1, 1'b1);
        wait_drain();
        check_value("unc_ren_o rising edges", unc_addrs.size(), 1);
        if (unc_addrs.size() == 1) check_value("unc_addr_o", unc_addrs[0], 32'h8000_3100);
        check_value("rd_req_o rising edges", line_addrs.size(), 0);
        fetch_and_count(32'h8000_3100, 1);
        end_test("uncached");

        start_test();
        issue_fetch(32'h0000_4140, 1'b0, 1'b0);
        n = 0;
        while (!rd_req && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (n >= WAIT_LIMIT) begin
            $display("line request for the flushed fetch never issued");
            errors++;
        end
        flush = 1'b1;
        @(negedge clk);
        flush = 1'b0;
        fetch_and_count(32'h0000_5140, 2);  // same set, old line must not land
        end_test("flush during refill");

        start_test();
        fetch_and_count(32'h0001_0180, 1);
        fetch_and_count(32'h0002_0180, 2);
        fetch_and_count(32'h0001_0180, 2);
        fetch_and_count(32'h0003_0180, 3);  // evicts the second line
        fetch_and_count(32'h0001_0180, 3);
        fetch_and_count(32'h0002_0180, 4);
        end_test("lru replacement");

        $display("%0d tests, %0d checks, %0d errors", test_no, checks, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    initial begin
        repeat (16 + NUM_TESTS * CYCLES_PER_TEST) @(posedge clk);
        $display("watchdog expired, run did not finish");
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

//--- tb_mem_model.sv
`timescale 1ns/10ps
`include "icache_defines.svh"

module tb_mem_model (
    input  logic              clk,
    input  logic              reset,
    input  logic              rd_req_i,
    input  icache_pkg::addr_t rd_addr_i,
    output logic              ret_valid_o,
    output icache_pkg::line_t ret_data_o,
    input  logic              unc_ren_i,
    input  icache_pkg::addr_t unc_addr_i,
    output logic              unc_rvalid_o,
    output icache_pkg::word_t unc_rdata_o
);
    import icache_pkg::*;

    integer seed = 32'haddd;

    logic  ret_valid_q  = 1'b0;
    line_t ret_data_q   = '0;
    logic  line_busy    = 1'b0;
    int    line_cnt     = 0;
    addr_t line_addr    = '0;
    logic  unc_rvalid_q = 1'b0;
    word_t unc_rdata_q  = '0;
    logic  unc_busy     = 1'b0;
    int    unc_cnt      = 0;
    addr_t unc_addr     = '0;

    // inverted address rotated left by 5
    function automatic word_t rule_word(input addr_t a);
        word_t w;
        w = ~a;
        return (w << 5) | (w >> 27);
    endfunction

    function automatic line_t rule_line(input addr_t base);
        line_t l;
        for (int i = 0; i < `ICACHE_LINE_WORDS; i++) begin
            l[32*i +: 32] = rule_word(base + 4 * i);
        end
        return l;
    endfunction

    function automatic word_t unc_word(input addr_t a);
        return a[31] ? (a ^ 32'h5a5a_0000) : rule_word(a);
    endfunction

    function automatic int pick_latency();
        return 1 + ($unsigned($random(seed)) % 12);  // 1 to 12 cycles
    endfunction

    // both channels in one block so the random sequence is fixed
    always @(negedge clk) begin
        if (reset) begin
            ret_valid_q  <= 1'b0;
            line_busy    <= 1'b0;
            unc_rvalid_q <= 1'b0;
            unc_busy     <= 1'b0;
        end else begin
            if (ret_valid_q) begin
                ret_valid_q <= 1'b0;
                line_busy   <= 1'b0;
            end else if (line_busy) begin
                line_cnt <= line_cnt - 1;
                if (line_cnt == 1) begin
                    ret_valid_q <= 1'b1;
                    ret_data_q  <= rule_line(line_addr);
                end
            end else if (rd_req_i) begin
                line_busy <= 1'b1;
                line_addr <= rd_addr_i;
                line_cnt  <= pick_latency();
            end
            if (unc_rvalid_q) begin
                unc_rvalid_q <= 1'b0;
                unc_busy     <= 1'b0;
            end else if (unc_busy) begin
                unc_cnt <= unc_cnt - 1;
                if (unc_cnt == 1) begin
                    unc_rvalid_q <= 1'b1;
                    unc_rdata_q  <= unc_word(unc_addr);
                end
            end else if (unc_ren_i) begin
                unc_busy <= 1'b1;
                unc_addr <= unc_addr_i;
                unc_cnt  <= pick_latency();
            end
        end
    end

    assign ret_valid_o  = ret_valid_q;
    assign ret_data_o   = ret_data_q;
    assign unc_rvalid_o = unc_rvalid_q;
    assign unc_rdata_o  = unc_rdata_q;

endmodule

//--- icache_top.sv
`timescale 1ns/10ps

module icache_top (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    fetch_en_i,
    input  icache_pkg::addr_t       fetch_pc_i,
    input  logic                    uncached_i,
    input  logic                    flush_i,
    output logic                    stall_o,
    output icache_pkg::fetch_resp_t resp_o,
    output logic                    rd_req_o,
    output icache_pkg::addr_t       rd_addr_o,
    input  logic                    ret_valid_i,
    input  icache_pkg::line_t       ret_data_i,
    output logic                    unc_ren_o,
    output icache_pkg::addr_t       unc_addr_o,
    input  logic                    unc_rvalid_i,
    input  icache_pkg::word_t       unc_rdata_i
);
    import icache_pkg::*;

    fetch_req_t req;
    logic       req_valid;
    index_t     rd_index_a, rd_index_b;
    tag_t [1:0] way_tag_a, way_tag_b;
    logic [1:0] way_valid_a, way_valid_b;
    word_t [1:0] way_word_a, way_word_b;
    logic [1:0] fill_en;
    index_t     fill_index;
    tag_t       fill_tag;
    wsel_t      word_sel_a, word_sel_b;
    logic       line_req, unc_req;
    addr_t      line_addr;
    mem_ret_t   mem_ret;

    fetch_req_stage u_stage (
        .clk, .reset, .fetch_en_i, .fetch_pc_i, .uncached_i,
        .stall_i      (stall_o),
        .flush_i,
        .req_o        (req),
        .req_valid_o  (req_valid),
        .rd_index_a_o (rd_index_a),
        .rd_index_b_o (rd_index_b)
    );

    for (genvar w = 0; w < 2; w++) begin : g_way
        icache_way_ram u_way (
            .clk, .reset,
            .rd_index_a_i (rd_index_a),
            .rd_index_b_i (rd_index_b),
            .wr_en_i      (fill_en[w]),
            .wr_index_i   (fill_index),
            .wr_tag_i     (fill_tag),
            .wr_line_i    (mem_ret.line),
            .word_sel_a_i (word_sel_a),
            .word_sel_b_i (word_sel_b),
            .hit_tag_a_o  (way_tag_a[w]),
            .hit_tag_b_o  (way_tag_b[w]),
            .valid_a_o    (way_valid_a[w]),
            .valid_b_o    (way_valid_b[w]),
            .word_a_o     (way_word_a[w]),
            .word_b_o     (way_word_b[w])
        );
    end

    icache_ctrl u_ctrl (
        .clk, .reset, .flush_i,
        .req_i         (req),
        .req_valid_i   (req_valid),
        .way_tag_a_i   (way_tag_a),
        .way_tag_b_i   (way_tag_b),
        .way_valid_a_i (way_valid_a),
        .way_valid_b_i (way_valid_b),
        .way_word_a_i  (way_word_a),
        .way_word_b_i  (way_word_b),
        .fill_en_o     (fill_en),
        .fill_index_o  (fill_index),
        .fill_tag_o    (fill_tag),
        .word_sel_a_o  (word_sel_a),
        .word_sel_b_o  (word_sel_b),
        .line_req_o    (line_req),
        .line_addr_o   (line_addr),
        .unc_req_o     (unc_req),
        .ret_i         (mem_ret),
        .stall_o,
        .resp_o
    );

    icache_mem_port u_mem_port (
        .clk, .reset, .flush_i,
        .line_req_i  (line_req),
        .line_addr_i (line_addr),
        .unc_req_i   (unc_req),
        .unc_addr_i  (req.pc),  // uncached reads use the held fetch pc
        .rd_req_o, .rd_addr_o, .ret_valid_i, .ret_data_i,
        .unc_ren_o, .unc_addr_o, .unc_rvalid_i, .unc_rdata_i,
        .ret_o       (mem_ret)
    );

endmodule

//--- icache_mem_port.sv
`timescale 1ns/10ps

module icache_mem_port (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 flush_i,
    input  logic                 line_req_i,
    input  icache_pkg::addr_t    line_addr_i,
    input  logic                 unc_req_i,
    input  icache_pkg::addr_t    unc_addr_i,
    output logic                 rd_req_o,
    output icache_pkg::addr_t    rd_addr_o,
    input  logic                 ret_valid_i,
    input  icache_pkg::line_t    ret_data_i,
    output logic                 unc_ren_o,
    output icache_pkg::addr_t    unc_addr_o,
    input  logic                 unc_rvalid_i,
    input  icache_pkg::word_t    unc_rdata_i,
    output icache_pkg::mem_ret_t ret_o
);
    import icache_pkg::*;

    logic  rd_pend_q;
    logic  unc_pend_q;
    logic  owe_q;  // a flushed request still has a return on the way
    logic  any_ret;
    addr_t rd_addr_q;
    addr_t unc_addr_q;

    assign any_ret = ret_valid_i || unc_rvalid_i;

    always_ff @(posedge clk) begin
        if (reset) begin
            owe_q <= 1'b0;
        end else if (flush_i && (rd_pend_q || unc_pend_q) && !any_ret) begin
            owe_q <= 1'b1;
        end else if (any_ret) begin
            owe_q <= 1'b0;
        end
    end

    // line read, no new issue until the owed return is gone
    always_ff @(posedge clk) begin
        if (reset || flush_i) begin
            rd_pend_q <= 1'b0;
        end else if (ret_valid_i) begin
            rd_pend_q <= 1'b0;
        end else if (line_req_i && !rd_pend_q && !owe_q) begin
            rd_pend_q <= 1'b1;
            rd_addr_q <= line_addr_i;
        end
    end

    always_ff @(posedge clk) begin
        if (reset || flush_i) begin
            unc_pend_q <= 1'b0;
        end else if (unc_rvalid_i) begin
            unc_pend_q <= 1'b0;
        end else if (unc_req_i && !unc_pend_q && !owe_q) begin
            unc_pend_q <= 1'b1;
            unc_addr_q <= unc_addr_i;
        end
    end

    assign rd_req_o   = rd_pend_q;
    assign rd_addr_o  = rd_addr_q;
    assign unc_ren_o  = unc_pend_q;
    assign unc_addr_o = unc_addr_q;

    assign ret_o.line_valid = ret_valid_i && !flush_i && !owe_q;
    assign ret_o.line       = ret_data_i;
    assign ret_o.word_valid = unc_rvalid_i && !flush_i && !owe_q;
    assign ret_o.word       = unc_rdata_i;

endmodule

//--- icache_ctrl.sv
`timescale 1ns/10ps
`include "icache_defines.svh"

module icache_ctrl (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     flush_i,
    input  icache_pkg::fetch_req_t   req_i,
    input  logic                     req_valid_i,
    input  icache_pkg::tag_t [1:0]   way_tag_a_i,
    input  icache_pkg::tag_t [1:0]   way_tag_b_i,
    input  logic [1:0]               way_valid_a_i,
    input  logic [1:0]               way_valid_b_i,
    input  icache_pkg::word_t [1:0]  way_word_a_i,
    input  icache_pkg::word_t [1:0]  way_word_b_i,
    output logic [1:0]               fill_en_o,
    output icache_pkg::index_t       fill_index_o,
    output icache_pkg::tag_t         fill_tag_o,
    output icache_pkg::wsel_t        word_sel_a_o,
    output icache_pkg::wsel_t        word_sel_b_o,
    output logic                     line_req_o,
    output icache_pkg::addr_t        line_addr_o,
    output logic                     unc_req_o,
    input  icache_pkg::mem_ret_t     ret_i,
    output logic                     stall_o,
    output icache_pkg::fetch_resp_t  resp_o
);
    import icache_pkg::*;

    icache_state_e state_q, state_d;

    logic [`ICACHE_SETS-1:0] lru_q;  // way to replace next
    logic   need_b_q;
    logic   unc_done_q;
    word_t  unc_word_q;

    addr_t  pc_a, pc_b, fill_pc;
    tag_t   tag_a, tag_b;
    index_t idx_a, idx_b;
    logic   same_line;
    logic   hit_a0, hit_a1, hit_b0, hit_b1;
    logic   hit_a, hit_b;
    logic   lookup, miss_a, miss_b;
    logic   filling, victim;
    logic   is_unc;

    assign pc_a  = req_i.pc;
    assign pc_b  = req_i.pc + 32'd4;
    assign tag_a = pc_a[31 -: `ICACHE_TAG_W];
    assign tag_b = pc_b[31 -: `ICACHE_TAG_W];
    assign idx_a = pc_a[`ICACHE_INDEX_LSB +: `ICACHE_INDEX_W];
    assign idx_b = pc_b[`ICACHE_INDEX_LSB +: `ICACHE_INDEX_W];
    assign same_line = pc_a[31:`ICACHE_OFFSET_W] == pc_b[31:`ICACHE_OFFSET_W];

    assign word_sel_a_o = pc_a[`ICACHE_WORD_LSB +: `ICACHE_WORD_SEL_W];
    assign word_sel_b_o = pc_b[`ICACHE_WORD_LSB +: `ICACHE_WORD_SEL_W];

    assign hit_a0 = way_valid_a_i[0] && way_tag_a_i[0] == tag_a;
    assign hit_a1 = way_valid_a_i[1] && way_tag_a_i[1] == tag_a;
    assign hit_b0 = way_valid_b_i[0] && way_tag_b_i[0] == tag_b;
    assign hit_b1 = way_valid_b_i[1] && way_tag_b_i[1] == tag_b;
    assign hit_a  = hit_a0 || hit_a1;
    assign hit_b  = hit_b0 || hit_b1;

    assign is_unc = req_valid_i && req_i.uncached;
    assign lookup = state_q == IDLE && req_valid_i && !req_i.uncached;
    assign miss_a = lookup && !hit_a;
    assign miss_b = lookup && !hit_b;

    // refill target
    assign fill_pc      = (state_q == FILL_B) ? pc_b : pc_a;
    assign fill_index_o = fill_pc[`ICACHE_INDEX_LSB +: `ICACHE_INDEX_W];
    assign fill_tag_o   = fill_pc[31 -: `ICACHE_TAG_W];
    assign victim       = lru_q[fill_index_o];
    assign filling      = (state_q == FILL_A || state_q == FILL_B) && ret_i.line_valid;
    assign fill_en_o    = filling ? (victim ? 2'b10 : 2'b01) : 2'b00;

    assign line_req_o  = state_q == FILL_A || state_q == FILL_B;
    assign line_addr_o = {fill_pc[31:`ICACHE_OFFSET_W], {`ICACHE_OFFSET_W{1'b0}}};
    assign unc_req_o   = state_q == UNCACHED;

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (is_unc && !unc_done_q) state_d = UNCACHED;
                else if (miss_a) state_d = FILL_A;
                else if (miss_b) state_d = FILL_B;
            end
            FILL_A: begin
                if (ret_i.line_valid) state_d = need_b_q ? FILL_B : IDLE;
            end
            FILL_B: begin
                if (ret_i.line_valid) state_d = IDLE;
            end
            UNCACHED: begin
                if (ret_i.word_valid) state_d = IDLE;
            end
            default: state_d = IDLE;
        endcase
        if (flush_i) state_d = IDLE;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q  <= IDLE;
            need_b_q <= 1'b0;
        end else begin
            state_q <= state_d;
            if (lookup) need_b_q <= miss_b && !same_line;  // second line still owed
        end
    end

    // one-cycle marker, the held request then answers from unc_word_q
    always_ff @(posedge clk) begin
        if (reset || flush_i) begin
            unc_done_q <= 1'b0;
        end else begin
            unc_done_q <= state_q == UNCACHED && ret_i.word_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == UNCACHED && ret_i.word_valid) unc_word_q <= ret_i.word;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            lru_q <= '0;
        end else if (filling) begin
            lru_q[fill_index_o] <= ~victim;
        end else if (lookup) begin
            if (hit_a) lru_q[idx_a] <= hit_a0;
            if (hit_b) lru_q[idx_b] <= hit_b0;
        end
    end

    assign stall_o = state_q != IDLE
                   || (is_unc && !unc_done_q)
                   || (lookup && !(hit_a && hit_b));

    always_comb begin
        resp_o.pc = pc_a;
        if (req_i.uncached) begin
            resp_o.valid     = state_q == IDLE && is_unc && unc_done_q && !flush_i;
            resp_o.slot_mask = 2'b01;
            resp_o.inst0     = unc_word_q;
            resp_o.inst1     = '0;
        end else begin
            resp_o.valid     = lookup && hit_a && hit_b && !flush_i;
            resp_o.slot_mask = 2'b11;
            resp_o.inst0     = hit_a0 ? way_word_a_i[0] : way_word_a_i[1];
            resp_o.inst1     = hit_b0 ? way_word_b_i[0] : way_word_b_i[1];
        end
    end

endmodule

//--- icache_way_ram.sv
`timescale 1ns/10ps
`include "icache_defines.svh"

module icache_way_ram (
    input  logic               clk,
    input  logic               reset,
    input  icache_pkg::index_t rd_index_a_i,
    input  icache_pkg::index_t rd_index_b_i,
    input  logic               wr_en_i,
    input  icache_pkg::index_t wr_index_i,
    input  icache_pkg::tag_t   wr_tag_i,
    input  icache_pkg::line_t  wr_line_i,
    input  icache_pkg::wsel_t  word_sel_a_i,
    input  icache_pkg::wsel_t  word_sel_b_i,
    output icache_pkg::tag_t   hit_tag_a_o,
    output icache_pkg::tag_t   hit_tag_b_o,
    output logic               valid_a_o,
    output logic               valid_b_o,
    output icache_pkg::word_t  word_a_o,
    output icache_pkg::word_t  word_b_o
);
    import icache_pkg::*;

    logic [`ICACHE_SETS-1:0] valid_q;
    tag_t                    tag_mem  [`ICACHE_SETS];
    line_t                   data_mem [`ICACHE_SETS];

    index_t rd_index [2];
    wsel_t  word_sel [2];
    logic   rd_valid_q [2];
    tag_t   rd_tag_q [2];
    line_t  rd_line_q [2];

    assign rd_index[0] = rd_index_a_i;
    assign rd_index[1] = rd_index_b_i;
    assign word_sel[0] = word_sel_a_i;
    assign word_sel[1] = word_sel_b_i;

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= '0;
        end else if (wr_en_i) begin
            valid_q[wr_index_i] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            tag_mem[wr_index_i]  <= wr_tag_i;
            data_mem[wr_index_i] <= wr_line_i;
        end
    end

    // write-first read, a fill is visible on the next lookup
    for (genvar p = 0; p < 2; p++) begin : g_port
        always_ff @(posedge clk) begin
            if (wr_en_i && wr_index_i == rd_index[p]) begin
                rd_valid_q[p] <= 1'b1;
                rd_tag_q[p]   <= wr_tag_i;
                rd_line_q[p]  <= wr_line_i;
            end else begin
                rd_valid_q[p] <= valid_q[rd_index[p]];
                rd_tag_q[p]   <= tag_mem[rd_index[p]];
                rd_line_q[p]  <= data_mem[rd_index[p]];
            end
        end
    end

    assign valid_a_o   = rd_valid_q[0];
    assign valid_b_o   = rd_valid_q[1];
    assign hit_tag_a_o = rd_tag_q[0];
    assign hit_tag_b_o = rd_tag_q[1];
    assign word_a_o    = rd_line_q[0][word_sel[0]*32 +: 32];
    assign word_b_o    = rd_line_q[1][word_sel[1]*32 +: 32];

endmodule

//--- fetch_req_stage.sv
`timescale 1ns/10ps
`include "icache_defines.svh"

module fetch_req_stage (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   fetch_en_i,
    input  icache_pkg::addr_t      fetch_pc_i,
    input  logic                   uncached_i,
    input  logic                   stall_i,
    input  logic                   flush_i,
    output icache_pkg::fetch_req_t req_o,
    output logic                   req_valid_o,
    output icache_pkg::index_t     rd_index_a_o,
    output icache_pkg::index_t     rd_index_b_o
);
    import icache_pkg::*;

    logic       accept;
    logic       req_valid_q;
    fetch_req_t req_q;
    addr_t      pc_b_live;
    addr_t      pc_b_q;

    assign accept    = fetch_en_i && !stall_i && !flush_i;
    assign pc_b_live = fetch_pc_i + 32'd4;  // second slot

    // lookup slot occupancy, held while the controller stalls
    always_ff @(posedge clk) begin
        if (reset || flush_i) begin
            req_valid_q <= 1'b0;
        end else if (!stall_i) begin
            req_valid_q <= fetch_en_i;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            req_q.pc       <= fetch_pc_i;
            req_q.uncached <= uncached_i;
            pc_b_q         <= pc_b_live;
        end
    end

    // live pc on accept, held pc while a miss is being served
    always_comb begin
        if (accept) begin
            rd_index_a_o = fetch_pc_i[`ICACHE_INDEX_LSB +: `ICACHE_INDEX_W];
            rd_index_b_o = pc_b_live[`ICACHE_INDEX_LSB +: `ICACHE_INDEX_W];
        end else begin
            rd_index_a_o = req_q.pc[`ICACHE_INDEX_LSB +: `ICACHE_INDEX_W];
            rd_index_b_o = pc_b_q[`ICACHE_INDEX_LSB +: `ICACHE_INDEX_W];
        end
    end

    assign req_o       = req_q;
    assign req_valid_o = req_valid_q;

endmodule

//--- icache_pkg.sv
`include "icache_defines.svh"

package icache_pkg;

    typedef logic [31:0]                  addr_t;
    typedef logic [31:0]                  word_t;
    typedef logic [`ICACHE_LINE_W-1:0]    line_t;  // word i at bits 32*i and up
    typedef logic [`ICACHE_TAG_W-1:0]     tag_t;
    typedef logic [`ICACHE_INDEX_W-1:0]   index_t;
    typedef logic [`ICACHE_WORD_SEL_W-1:0] wsel_t;

    // one-hot controller states
    typedef enum logic [3:0] {
        IDLE     = 4'b0001,
        FILL_A   = 4'b0010,
        FILL_B   = 4'b0100,
        UNCACHED = 4'b1000
    } icache_state_e;

    // registered fetch request
    typedef struct packed {
        addr_t pc;
        logic  uncached;
    } fetch_req_t;

    typedef struct packed {
        logic       valid;
        logic [1:0] slot_mask;  // bit 0 is inst0
        addr_t      pc;
        word_t      inst0;
        word_t      inst1;
    } fetch_resp_t;

    // memory returns after flush filtering
    typedef struct packed {
        logic  line_valid;
        line_t line;
        logic  word_valid;
        word_t word;
    } mem_ret_t;

endpackage

//--- icache_defines.svh
`ifndef ICACHE_DEFINES_SVH
`define ICACHE_DEFINES_SVH

// address split for a 32-bit byte address
// tag | index | offset
`define ICACHE_TAG_W      20
`define ICACHE_INDEX_W    7
`define ICACHE_OFFSET_W   5

// geometry
`define ICACHE_SETS       128
`define ICACHE_LINE_WORDS 8

// word select inside a line, offset without the byte bits
`define ICACHE_WORD_SEL_W 3

// full line width in bits
`define ICACHE_LINE_W     (`ICACHE_LINE_WORDS * 32)

// low bit of the index field
`define ICACHE_INDEX_LSB  `ICACHE_OFFSET_W

// low bit of the word select field
`define ICACHE_WORD_LSB   2

`endif
